// File: design/spi_flash_pkg.sv
package spi_flash_pkg;

    // Bus and SPI widths
    typedef logic [31:0] data_t;
    typedef logic [31:0] adr_t;
    typedef logic [7:0]  byte_t;

    // Register index from address bits 3..2
    typedef logic [1:0]  reg_idx_t;

    localparam reg_idx_t REG_CTRL   = 2'd0;
    localparam reg_idx_t REG_DIV    = 2'd1;
    localparam reg_idx_t REG_DATA   = 2'd2;
    localparam reg_idx_t REG_STATUS = 2'd3;

    // Wishbone classic request, master to slave
    typedef struct packed {
        adr_t  adr;
        data_t dat;
        logic  we;
        logic  stb;
        logic  cyc;
    } wb_req_t;

    // Wishbone classic response, slave to master
    typedef struct packed {
        data_t dat;
        logic  ack;
    } wb_rsp_t;

    // Transfer sequencer states
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_LEAD  = 2'd1,
        ST_TRAIL = 2'd2,
        ST_DONE  = 2'd3
    } xfer_state_t;

endpackage

// File: design/spi_clk_div.sv
`timescale 1ns/10ps

module spi_clk_div #(
    parameter int DIV_W = 8
) (
    input  logic             wb_clk_i,
    input  logic             reset_i,

    input  logic             run_i,
    input  logic [DIV_W-1:0] div_i,

    output logic             tick_o,
    output logic             sck_o
);

    logic [DIV_W-1:0] cnt_q;
    logic             sck_q;

    // Half period is div_i + 1 clocks
    assign tick_o = run_i & (cnt_q == '0);

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            cnt_q <= '0;
            sck_q <= 1'b0;
        end else if (!run_i) begin
            // Idle low, counter primed for the next byte
            cnt_q <= div_i;
            sck_q <= 1'b0;
        end else if (tick_o) begin
            cnt_q <= div_i;
            sck_q <= ~sck_q;
        end else begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign sck_o = sck_q;

endmodule

// File: design/spi_shift_reg.sv
`timescale 1ns/10ps

module spi_shift_reg import spi_flash_pkg::*; (
    input  logic  wb_clk_i,
    input  logic  reset_i,

    input  logic  load_i,
    input  logic  sample_i,
    input  logic  shift_i,
    input  byte_t tx_byte_i,

    input  logic  miso_i,
    output logic  mosi_o,
    output byte_t rx_byte_o
);

    byte_t sreg_q;
    logic  miso_hold_q;

    // Transmit bits leave at the MSB, received bits enter at the LSB
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            sreg_q <= '0;
        end else if (load_i) begin
            sreg_q <= tx_byte_i;
        end else if (shift_i) begin
            sreg_q <= {sreg_q[6:0], miso_hold_q};
        end
    end

    // MISO captured on SCK rise, shifted in on SCK fall
    always_ff @(posedge wb_clk_i) begin
        if (sample_i) begin
            miso_hold_q <= miso_i;
        end
    end

    assign mosi_o    = sreg_q[7];
    assign rx_byte_o = sreg_q;

endmodule

// File: design/spi_xfer_fsm.sv
`timescale 1ns/10ps

module spi_xfer_fsm import spi_flash_pkg::*; (
    input  logic wb_clk_i,
    input  logic reset_i,

    input  logic start_i,
    input  logic tick_i,

    output logic run_o,
    output logic load_o,
    output logic sample_o,
    output logic shift_o,
    output logic busy_o,
    output logic done_o
);

    xfer_state_t state_q;
    xfer_state_t state_d;
    logic [2:0]  bit_cnt_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start_i) begin
                    state_d = ST_LEAD;
                end
            end
            ST_LEAD: begin
                // SCK rising edge
                if (tick_i) begin
                    state_d = ST_TRAIL;
                end
            end
            ST_TRAIL: begin
                // SCK falling edge, last one ends the byte
                if (tick_i) begin
                    state_d = (bit_cnt_q == 3'd7) ? ST_DONE : ST_LEAD;
                end
            end
            ST_DONE: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state_q   <= ST_IDLE;
            bit_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (load_o) begin
                bit_cnt_q <= '0;
            end else if (shift_o) begin
                bit_cnt_q <= bit_cnt_q + 3'd1;
            end
        end
    end

    assign load_o   = (state_q == ST_IDLE) & start_i;
    assign sample_o = (state_q == ST_LEAD) & tick_i;
    assign shift_o  = (state_q == ST_TRAIL) & tick_i;
    assign busy_o   = (state_q == ST_LEAD) | (state_q == ST_TRAIL);
    assign run_o    = busy_o;
    assign done_o   = (state_q == ST_DONE);

endmodule

// File: design/spi_wb_regs.sv
`timescale 1ns/10ps

module spi_wb_regs import spi_flash_pkg::*; #(
    parameter int DIV_W = 8
) (
    input  logic             wb_clk_i,
    input  logic             reset_i,

    input  wb_req_t          wb_req_i,
    output wb_rsp_t          wb_rsp_o,

    input  logic             busy_i,
    input  logic             done_i,
    input  byte_t            rx_byte_i,

    output logic             start_o,
    output byte_t            tx_byte_o,
    output logic [DIV_W-1:0] div_o,
    output logic             cs_n_o,
    output logic             irq_o
);

    // CTRL bit positions
    localparam int CTRL_EN = 0;
    localparam int CTRL_IE = 1;
    localparam int CTRL_CS = 2;

    // STATUS bit positions
    localparam int STAT_BUSY = 0;
    localparam int STAT_DONE = 1;

    logic             live;
    logic             access;
    logic             wr;
    reg_idx_t         idx;

    logic             ack_q;
    data_t            rd_data;
    data_t            rd_q;

    logic [2:0]       ctrl_q;
    logic [DIV_W-1:0] div_q;
    logic             done_q;
    logic             start_q;
    byte_t            tx_q;

    assign live   = wb_req_i.stb & wb_req_i.cyc;
    // First cycle of a live request, ack follows on the next one
    assign access = live & ~ack_q;
    assign wr     = access & wb_req_i.we;
    assign idx    = wb_req_i.adr[3:2];

    always_comb begin
        rd_data = '0;
        case (idx)
            REG_CTRL: begin
                rd_data = {29'd0, ctrl_q};
            end
            REG_DIV: begin
                rd_data = data_t'(div_q);
            end
            REG_DATA: begin
                rd_data = {24'd0, rx_byte_i};
            end
            REG_STATUS: begin
                rd_data[STAT_BUSY] = busy_i;
                rd_data[STAT_DONE] = done_q;
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_q   <= 1'b0;
            ctrl_q  <= '0;
            div_q   <= '0;
            done_q  <= 1'b0;
            start_q <= 1'b0;
        end else begin
            ack_q   <= access;
            // Start only when enabled, the FSM drops it if not idle
            start_q <= wr && (idx == REG_DATA) && ctrl_q[CTRL_EN];

            if (wr && (idx == REG_CTRL)) begin
                ctrl_q <= wb_req_i.dat[2:0];
            end
            if (wr && (idx == REG_DIV)) begin
                div_q <= wb_req_i.dat[DIV_W-1:0];
            end

            // New completion wins over a clear in the same cycle
            if (done_i) begin
                done_q <= 1'b1;
            end else if (wr && (idx == REG_STATUS) && wb_req_i.dat[STAT_DONE]) begin
                done_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            rd_q <= rd_data;
        end
        if (wr && (idx == REG_DATA)) begin
            tx_q <= wb_req_i.dat[7:0];
        end
    end

    assign wb_rsp_o.dat = rd_q;
    assign wb_rsp_o.ack = ack_q;

    assign start_o   = start_q;
    assign tx_byte_o = tx_q;
    assign div_o     = div_q;
    assign cs_n_o    = ~ctrl_q[CTRL_CS];
    assign irq_o     = done_q & ctrl_q[CTRL_IE];

endmodule

// File: design/spi_flash_top.sv
`timescale 1ns/10ps

module spi_flash_top import spi_flash_pkg::*; #(
    parameter int DIV_W = 8
) (
    input  logic    wb_clk_i,
    input  logic    reset_i,

    // Wishbone slave port
    input  wb_req_t wb_req_i,
    output wb_rsp_t wb_rsp_o,

    // Flash pins
    input  logic    flash_miso_i,
    output logic    flash_sck_o,
    output logic    flash_cs_n_o,
    output logic    flash_mosi_o,

    output logic    irq_o
);

    logic [DIV_W-1:0] div;
    logic             start;
    byte_t            tx_byte;
    byte_t            rx_byte;
    logic             run;
    logic             load;
    logic             sample;
    logic             shift;
    logic             busy;
    logic             done;
    logic             tick;

    spi_wb_regs #(
        .DIV_W      (DIV_W)
    ) u_regs (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .wb_req_i   (wb_req_i),
        .busy_i     (busy),
        .done_i     (done),
        .rx_byte_i  (rx_byte),
        .wb_rsp_o   (wb_rsp_o),
        .start_o    (start),
        .tx_byte_o  (tx_byte),
        .div_o      (div),
        .cs_n_o     (flash_cs_n_o),
        .irq_o      (irq_o)
    );

    spi_xfer_fsm u_fsm (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .start_i    (start),
        .tick_i     (tick),
        .run_o      (run),
        .load_o     (load),
        .sample_o   (sample),
        .shift_o    (shift),
        .busy_o     (busy),
        .done_o     (done)
    );

    spi_clk_div #(
        .DIV_W      (DIV_W)
    ) u_clk_div (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .run_i      (run),
        .div_i      (div),
        .tick_o     (tick),
        .sck_o      (flash_sck_o)
    );

    spi_shift_reg u_shift (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .load_i     (load),
        .sample_i   (sample),
        .shift_i    (shift),
        .tx_byte_i  (tx_byte),
        .miso_i     (flash_miso_i),
        .mosi_o     (flash_mosi_o),
        .rx_byte_o  (rx_byte)
    );

endmodule

// File: test/tb_flash_model.sv
`timescale 1ns/10ps

module tb_flash_model import spi_flash_pkg::*; (
    input  logic  sck_i,
    input  logic  cs_n_i,
    input  logic  mosi_i,
    output logic  miso_o,
    output int    count_o,
    output byte_t last_o
);

    byte_t rx_sh;
    byte_t tx_sh;
    byte_t reply;
    int    bit_cnt;

    initial begin
        rx_sh   = '0;
        tx_sh   = 8'hA5;
        reply   = 8'hA5;
        bit_cnt = 0;
        count_o = 0;
        last_o  = '0;
    end

    // Mode 0 slave samples MOSI on SCK rise
    always @(posedge sck_i) begin
        if (!cs_n_i) begin
            rx_sh = {rx_sh[6:0], mosi_i};
            bit_cnt++;
            if (bit_cnt == 8) begin
                bit_cnt = 0;
                last_o  = rx_sh;
                count_o = count_o + 1;
                // Next reply is the complement of this byte
                reply = ~rx_sh;
            end
        end
    end

    // MISO moves on SCK fall and takes the next reply after a full byte
    always @(negedge sck_i) begin
        if (!cs_n_i) begin
            if (bit_cnt == 0) begin
                tx_sh = reply;
            end else begin
                tx_sh = {tx_sh[6:0], 1'b0};
            end
        end
    end

    assign miso_o = tx_sh[7];

endmodule

// File: test/tb_spi_flash_top.sv
`timescale 1ns/10ps

module tb_spi_flash_top import spi_flash_pkg::*; ();

    localparam int CLK_NS         = 20;
    localparam int NUM_TESTS      = 6;
    localparam int XFERS_PER_TEST = 20;
    localparam int MAX_DIV        = 5;
    localparam int POLL_LIMIT     = 2000;

    logic    clk;
    logic    reset;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    flash_miso;
    logic    flash_sck;
    logic    flash_cs_n;
    logic    flash_mosi;
    logic    irq;
    int      model_count;
    byte_t   model_last;

    int      n_pass;
    int      n_fail;
    int      fail_mark;
    int      test_no;
    integer  seed;
    logic [2:0] ctrl_shadow;
    logic    sent_any;
    byte_t   last_sent;
    byte_t   pend_byte;
    byte_t   pend_exp;
    int      pend_cnt;

    spi_flash_top #(
        .DIV_W        (8)
    ) u_dut (
        .wb_clk_i     (clk),
        .reset_i      (reset),
        .wb_req_i     (wb_req),
        .wb_rsp_o     (wb_rsp),
        .flash_miso_i (flash_miso),
        .flash_sck_o  (flash_sck),
        .flash_cs_n_o (flash_cs_n),
        .flash_mosi_o (flash_mosi),
        .irq_o        (irq)
    );

    tb_flash_model u_model (
        .sck_i   (flash_sck),
        .cs_n_i  (flash_cs_n),
        .mosi_i  (flash_mosi),
        .miso_o  (flash_miso),
        .count_o (model_count),
        .last_o  (model_last)
    );

    always #(CLK_NS / 2) clk = ~clk;

    assert property (@(posedge clk) disable iff (reset) wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            n_fail++;
            $display("ack stayed high for more than one cycle at %0t ns", $time);
        end

    assert property (@(posedge clk) disable iff (reset) flash_cs_n |-> !flash_sck)
        else begin
            n_fail++;
            $display("SCK was high while chip select was inactive at %0t ns", $time);
        end

    assert property (@(posedge clk) disable iff (reset)
                     flash_cs_n && $past(flash_cs_n) |-> $stable(flash_mosi))
        else begin
            n_fail++;
            $display("MOSI moved while chip select was inactive at %0t ns", $time);
        end

    // STATUS data and irq are both taken from the cycle before ack
    assert property (@(posedge clk) disable iff (reset)
                     wb_rsp.ack && !wb_req.we && wb_req.adr[3:2] == REG_STATUS
                     |-> $past(irq) == (wb_rsp.dat[1] & ctrl_shadow[1]))
        else begin
            n_fail++;
            $display("irq did not match done and interrupt enable at %0t ns", $time);
        end

    assert property (@(posedge clk) disable iff (reset) flash_cs_n == !ctrl_shadow[2])
        else begin
            n_fail++;
            $display("Chip select did not follow the CTRL register at %0t ns", $time);
        end

    task automatic check_value(input string name, input data_t exp, input data_t act);
        assert (act === exp) begin
            n_pass++;
        end else begin
            n_fail++;
            $display("Mismatch at %0t ns: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic end_test(input string name);
        test_no++;
        if (n_fail == fail_mark) begin
            $display("Test %0d %s: ok", test_no, name);
        end else begin
            $display("Test %0d %s: %0d errors", test_no, name, n_fail - fail_mark);
        end
        fail_mark = n_fail;
    endtask

    function automatic byte_t next_byte();
        integer r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic bus_access(input reg_idx_t idx, input logic we, input data_t wdat,
                              input int hold, output data_t rdat);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_req.adr = {28'd0, idx, 2'b00};
        wb_req.dat = wdat;
        wb_req.we  = we;
        wb_req.stb = 1'b1;
        wb_req.cyc = 1'b1;
        @(negedge clk);
        while (!wb_rsp.ack && waited < 16) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_rsp.ack) begin
            n_fail++;
            $display("No ack for register %0d at %0t ns", idx, $time);
        end
        rdat = wb_rsp.dat;
        // Request may stay live for a while after ack
        repeat (hold) @(negedge clk);
        wb_req.stb = 1'b0;
        wb_req.cyc = 1'b0;
        if (we && idx == REG_CTRL) begin
            ctrl_shadow = wdat[2:0];
        end
    endtask

    task automatic wb_write(input reg_idx_t idx, input data_t wdat);
        data_t unused;
        bus_access(idx, 1'b1, wdat, 0, unused);
    endtask

    task automatic wb_read(input reg_idx_t idx, output data_t rdat);
        bus_access(idx, 1'b0, '0, 0, rdat);
    endtask

    task automatic read_with_held_stb(input reg_idx_t idx, output data_t rdat);
        bus_access(idx, 1'b0, '0, 1, rdat);
    endtask

    task automatic wait_status(input int pos, input logic level);
        data_t st;
        int    polls;
        polls = 0;
        wb_read(REG_STATUS, st);
        while (st[pos] !== level && polls < POLL_LIMIT) begin
            wb_read(REG_STATUS, st);
            polls++;
        end
        if (st[pos] !== level) begin
            n_fail++;
            $display("STATUS bit %0d never reached %0b at %0t ns", pos, level, $time);
        end
    endtask

    task automatic start_xfer(input byte_t b);
        pend_byte = b;
        pend_exp  = sent_any ? ~last_sent : 8'hA5;
        pend_cnt  = model_count;
        wb_write(REG_DATA, b);
    endtask

    task automatic finish_xfer();
        data_t rd;
        wait_status(0, 1'b0);
        check_value("model byte count", pend_cnt + 1, model_count);
        check_value("model received byte", pend_byte, model_last);
        wb_read(REG_DATA, rd);
        check_value("DATA", pend_exp, rd);
        last_sent = pend_byte;
        sent_any  = 1'b1;
    endtask

    task automatic check_sck_phases(input int div);
        int   len;
        int   edges;
        int   guard;
        logic prev;
        guard = 0;
        while (flash_sck !== 1'b1 && guard < 1000) begin
            @(negedge clk);
            guard++;
        end
        if (flash_sck !== 1'b1) begin
            n_fail++;
            $display("SCK never rose during the transfer at %0t ns", $time);
        end else begin
            prev = 1'b1;
            for (edges = 1; edges < 16; edges++) begin
                len = 0;
                while (flash_sck === prev && len < 1000) begin
                    @(negedge clk);
                    len++;
                end
                check_value("flash_sck_o phase length", div + 1, len);
                prev = flash_sck;
            end
        end
    endtask

    initial begin
        #(NUM_TESTS * XFERS_PER_TEST * 16 * (MAX_DIV + 1) * CLK_NS);
        $display("Watchdog expired before the tests completed");
        $display("Checks failed");
        $finish;
    end

    initial begin
        data_t rd;
        int    cnt0;
        clk         = 1'b0;
        reset       = 1'b1;
        wb_req      = '0;
        n_pass      = 0;
        n_fail      = 0;
        fail_mark   = 0;
        test_no     = 0;
        seed        = 32'h0068_3fd5;
        ctrl_shadow = '0;
        sent_any    = 1'b0;
        last_sent   = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        wb_read(REG_STATUS, rd);
        check_value("STATUS", 0, rd);
        check_value("flash_cs_n_o", 1, flash_cs_n);
        check_value("flash_sck_o", 0, flash_sck);
        wb_read(REG_CTRL, rd);
        check_value("CTRL", 0, rd);
        wb_write(REG_CTRL, 32'h5);
        wb_read(REG_CTRL, rd);
        check_value("CTRL", 32'h5, rd);
        wb_write(REG_DIV, 32'h3c);
        read_with_held_stb(REG_DIV, rd);
        check_value("DIV", 32'h3c, rd);
        end_test("reset and register access");

        wb_write(REG_DIV, 32'd2);
        wb_write(REG_CTRL, 32'h5);
        for (int i = 0; i < 10; i++) begin
            start_xfer(next_byte());
            wait_status(0, 1'b1);
            finish_xfer();
        end
        end_test("ten byte transfers");

        for (int div = 0; div <= MAX_DIV; div += MAX_DIV) begin
            wb_write(REG_DIV, div);
            start_xfer(next_byte());
            check_sck_phases(div);
            finish_xfer();
        end
        end_test("SCK half period");

        wb_write(REG_DIV, 32'd2);
        wb_write(REG_CTRL, 32'h7);
        wb_write(REG_STATUS, 32'h2);
        start_xfer(next_byte());
        wait_status(0, 1'b1);
        finish_xfer();
        wait_status(1, 1'b1);
        check_value("irq_o", 1, irq);
        wb_write(REG_STATUS, 32'h2);
        check_value("irq_o", 0, irq);
        wb_write(REG_CTRL, 32'h5);
        start_xfer(next_byte());
        wait_status(0, 1'b1);
        finish_xfer();
        wait_status(1, 1'b1);
        check_value("irq_o", 0, irq);
        wb_write(REG_STATUS, 32'h2);
        end_test("interrupt");

        start_xfer(next_byte());
        wait_status(0, 1'b1);
        wb_write(REG_DATA, next_byte());
        finish_xfer();
        wb_write(REG_CTRL, 32'h4);
        cnt0 = model_count;
        wb_write(REG_DATA, next_byte());
        wb_read(REG_STATUS, rd);
        check_value("STATUS busy", 0, rd[0]);
        wb_read(REG_STATUS, rd);
        check_value("STATUS busy", 0, rd[0]);
        repeat (16 * 3 + 4) @(negedge clk);
        check_value("model byte count", cnt0, model_count);
        wb_write(REG_CTRL, 32'h5);
        end_test("dropped DATA writes");

        wb_write(REG_CTRL, 32'h0);
        check_value("flash_cs_n_o", 1, flash_cs_n);
        wb_write(REG_CTRL, 32'h4);
        check_value("flash_cs_n_o", 0, flash_cs_n);
        wb_write(REG_CTRL, 32'h1);
        check_value("flash_cs_n_o", 1, flash_cs_n);
        wb_write(REG_CTRL, 32'h5);
        check_value("flash_cs_n_o", 0, flash_cs_n);
        end_test("chip select");

        $display("Checks: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: src.f
design/spi_flash_pkg.sv
design/spi_clk_div.sv
design/spi_shift_reg.sv
design/spi_xfer_fsm.sv
design/spi_wb_regs.sv
design/spi_flash_top.sv
test/tb_flash_model.sv
test/tb_spi_flash_top.sv
